// ==== hdl/button_mode_map.sv ====
`timescale 1ns/1ps

module button_mode_map (
    // only clocks the assertion below
    input  logic               clk,
    input  logic [1:0]         sw,
    input  logic [3:0]         btn,
    output player_pkg::lbtn_t  raw_lines
);

    // ==============================
    // panel layouts
    // ==============================

    always_comb begin
        // unmapped lines stay low
        raw_lines = '0;
        case (sw)
            // basic layout
            // btn[0] has no function here
            2'b00: begin
                raw_lines[player_pkg::btn_stop] = btn[3];
                raw_lines[player_pkg::btn_play] = btn[2];
                raw_lines[player_pkg::btn_next] = btn[1];
            end
            // transport layout, both switch codes
            2'b01, 2'b11: begin
                raw_lines[player_pkg::btn_stop] = btn[3];
                raw_lines[player_pkg::btn_play] = btn[2];
                raw_lines[player_pkg::btn_rew]  = btn[1];
                raw_lines[player_pkg::btn_ff]   = btn[0];
            end
            // 2'b10 is the panel-locked mode
            // every line held low
            default: begin
                raw_lines = '0;
            end
        endcase
    end

    // ==============================
    // checks
    // ==============================

    // basic layout has no seek buttons
    // so the seek lines must be quiet downstream as well
    a_no_seek_in_basic: assert property (
        @(posedge clk)
        (sw == 2'b00) |->
            !(raw_lines[player_pkg::btn_rew] || raw_lines[player_pkg::btn_ff])
    ) else $error("seek line high in basic panel mode");

endmodule

// ==== hdl/button_press_unit.sv ====
`timescale 1ns/1ps

module button_press_unit #(
    // stable time is 2**DEBOUNCE_WIDTH - 1 cycles
    parameter int DEBOUNCE_WIDTH = 20
) (
    input  logic clk,
    input  logic rst_n,
    input  logic raw,
    output logic press
);

    // counter limits
    localparam logic [DEBOUNCE_WIDTH-1:0] cnt_max  = '1;
    localparam logic [DEBOUNCE_WIDTH-1:0] cnt_last = cnt_max - 1'b1;

    // synchronizer stages
    logic                      sync_q1;
    logic                      sync_q2;

    // stable-high counter
    logic [DEBOUNCE_WIDTH-1:0] stable_cnt;

    // ==============================
    // input synchronizer
    // ==============================

    // two flops against metastability on the raw pin
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= raw;
            sync_q2 <= sync_q1;
        end
    end

    // ==============================
    // debounce and pulse
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stable_cnt <= '0;
        end else if (!sync_q2) begin
            // any low cycle restarts the count
            stable_cnt <= '0;
        end else if (stable_cnt != cnt_max) begin
            stable_cnt <= stable_cnt + 1'b1;
        end
        // saturated otherwise, held until release
    end

    // pulse lands in the cycle the count hits max
    // after that the count sits at max so no repeat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            press <= 1'b0;
        end else begin
            press <= sync_q2 && (stable_cnt == cnt_last);
        end
    end

    // a held button must never produce back-to-back pulses
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        press |=> !press
    ) else $error("press pulse longer than one cycle");

endmodule

// ==== hdl/music_control_top.sv ====
`timescale 1ns/1ps

module music_control_top #(
    // debounce, kept small in simulation
    parameter int DEBOUNCE_WIDTH = 20,
    // cycles per beat
    parameter int BEAT_COUNT     = 1000,
    // song count, at most 16
    parameter int NUM_SONGS      = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [3:0]                 btn,
    input  logic [1:0]                 sw,
    output player_pkg::player_state_t  state,
    output player_pkg::song_t          song,
    output player_pkg::beat_t          position,
    output logic                       beat
);

    // mapped button levels
    player_pkg::lbtn_t raw_lines;
    // one-cycle press pulses
    player_pkg::lbtn_t press;

    // ==============================
    // panel mapping
    // ==============================

    button_mode_map u_mode_map (
        .clk       (clk),
        .sw        (sw),
        .btn       (btn),
        .raw_lines (raw_lines)
    );

    // ==============================
    // press units
    // ==============================

    // identical debouncer per logical line
    for (genvar i = 0; i < player_pkg::num_buttons; i++) begin : g_press
        button_press_unit #(
            .DEBOUNCE_WIDTH (DEBOUNCE_WIDTH)
        ) u_press (
            .clk   (clk),
            .rst_n (rst_n),
            .raw   (raw_lines[i]),
            .press (press[i])
        );
    end

    // ==============================
    // player controller
    // ==============================

    player_control #(
        .BEAT_COUNT (BEAT_COUNT),
        .NUM_SONGS  (NUM_SONGS)
    ) u_player (
        .clk      (clk),
        .rst_n    (rst_n),
        .press    (press),
        .state    (state),
        .song     (song),
        .position (position),
        .beat     (beat)
    );

endmodule

// ==== hdl/player_control.sv ====
`timescale 1ns/1ps

module player_control #(
    // clock cycles per beat
    parameter int BEAT_COUNT = 1000,
    // song number wraps here, at most 16
    parameter int NUM_SONGS  = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  player_pkg::lbtn_t          press,
    output player_pkg::player_state_t  state,
    output player_pkg::song_t          song,
    output player_pkg::beat_t          position,
    output logic                       beat
);

    // timer sizing, at least one bit
    localparam int timer_w = (BEAT_COUNT > 1) ? $clog2(BEAT_COUNT) : 1;

    typedef logic [timer_w-1:0] timer_t;

    localparam timer_t            timer_last = timer_t'(BEAT_COUNT - 1);
    localparam player_pkg::song_t last_song  = player_pkg::song_t'(NUM_SONGS - 1);

    player_pkg::player_state_t state_nx;
    player_pkg::song_t         song_nx;
    player_pkg::beat_t         pos_nx;
    timer_t                    beat_timer;
    timer_t                    timer_nx;
    // stop or next forces position to 0
    logic                      clear_pos;
    // timer restart on a state change or forced position
    logic                      restart;
    // beat boundary this cycle
    logic                      tick;

    // ==============================
    // transport decode
    // ==============================

    // one button acted on per cycle
    // priority stop, next, play, rewind, ff
    always_comb begin
        state_nx  = state;
        song_nx   = song;
        clear_pos = 1'b0;
        if (press[player_pkg::btn_stop]) begin
            state_nx  = player_pkg::st_paused;
            clear_pos = 1'b1;
        end else if (press[player_pkg::btn_next]) begin
            // state untouched on a song skip
            song_nx   = (song == last_song) ? '0 : song + 1'b1;
            clear_pos = 1'b1;
        end else if (press[player_pkg::btn_play]) begin
            // play toggles only against st_play
            if (state == player_pkg::st_play) begin
                state_nx = player_pkg::st_paused;
            end else begin
                state_nx = player_pkg::st_play;
            end
        end else if (press[player_pkg::btn_rew]) begin
            // seek ignored while paused
            if (state != player_pkg::st_paused) begin
                state_nx = player_pkg::st_rewind;
            end
        end else if (press[player_pkg::btn_ff]) begin
            if (state != player_pkg::st_paused) begin
                state_nx = player_pkg::st_fast;
            end
        end
    end

    // ==============================
    // beat timer and position
    // ==============================

    assign restart = (state_nx != state) || clear_pos;

    // a boundary that collides with a restart is dropped
    assign tick = (state != player_pkg::st_paused) && (beat_timer == timer_last) && !restart;

    always_comb begin
        // idle in pause, wrap at the boundary
        if (restart || (state == player_pkg::st_paused) || (beat_timer == timer_last)) begin
            timer_nx = '0;
        end else begin
            timer_nx = beat_timer + 1'b1;
        end
    end

    always_comb begin
        pos_nx = position;
        if (clear_pos) begin
            pos_nx = '0;
        end else if (tick) begin
            case (state)
                player_pkg::st_play:   pos_nx = position + 8'd1;
                player_pkg::st_fast:   pos_nx = position + 8'd2;
                // rewind stops at the song start
                player_pkg::st_rewind: pos_nx = (position == '0) ? '0 : position - 8'd1;
                default:               pos_nx = position;
            endcase
        end
    end

    // all outputs registered, one cycle after the pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= player_pkg::st_paused;
            song       <= '0;
            position   <= '0;
            beat_timer <= '0;
            beat       <= 1'b0;
        end else begin
            state      <= state_nx;
            song       <= song_nx;
            position   <= pos_nx;
            beat_timer <= timer_nx;
            beat       <= tick;
        end
    end

    // beat follows a tick of an unchanged running state
    a_no_beat_paused: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat |-> (state != player_pkg::st_paused)
    ) else $error("beat pulse while paused");

    a_song_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        song < NUM_SONGS
    ) else $error("song number out of range");

endmodule

// ==== hdl/player_pkg.sv ====
package player_pkg;

    // ==============================
    // logical button vector
    // ==============================

    // number of logical player buttons
    localparam int num_buttons = 5;

    // bit positions in the logical button vector
    localparam int btn_stop = 0;
    localparam int btn_play = 1;
    localparam int btn_next = 2;
    localparam int btn_rew  = 3;
    localparam int btn_ff   = 4;

    // one line per logical button
    typedef logic [num_buttons-1:0] lbtn_t;

    // ==============================
    // player data widths
    // ==============================

    // song number, wraps at NUM_SONGS in the controller
    typedef logic [3:0] song_t;

    // beat position within a song, wraps mod 256
    typedef logic [7:0] beat_t;

    // transport modes
    typedef enum logic [1:0] {
        st_paused,
        st_play,
        st_rewind,
        st_fast
    } player_state_t;

endpackage

// ==== music_control_top.f ====
+incdir+verif
hdl/player_pkg.sv
hdl/button_mode_map.sv
hdl/button_press_unit.sv
hdl/player_control.sv
hdl/music_control_top.sv
verif/music_control_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module music_control_tb \
    -f music_control_top.f -o music_control_sim \
    && ./obj_dir/music_control_sim | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verif/player_model.svh ====
`ifndef PLAYER_MODEL_SVH
`define PLAYER_MODEL_SVH

// ==============================
// transport reference
// ==============================

// lb is a logical button index, -1 when no press is accepted
function automatic void predict_press(
    input  int                         lb,
    input  int                         songs,
    input  player_pkg::player_state_t  cur_state,
    input  player_pkg::song_t          cur_song,
    input  player_pkg::beat_t          cur_pos,
    output player_pkg::player_state_t  new_state,
    output player_pkg::song_t          new_song,
    output player_pkg::beat_t          new_pos
);
    new_state = cur_state;
    new_song  = cur_song;
    new_pos   = cur_pos;
    if (lb == player_pkg::btn_stop) begin
        new_state = player_pkg::st_paused;
        new_pos   = 8'd0;
    end else if (lb == player_pkg::btn_next) begin
        // skip keeps the transport mode
        new_song = (int'(cur_song) + 1 >= songs) ? 4'd0 : cur_song + 4'd1;
        new_pos  = 8'd0;
    end else if (lb == player_pkg::btn_play) begin
        if (cur_state == player_pkg::st_play) new_state = player_pkg::st_paused;
        else new_state = player_pkg::st_play;
    end else if (lb == player_pkg::btn_rew && cur_state != player_pkg::st_paused) begin
        new_state = player_pkg::st_rewind;
    end else if (lb == player_pkg::btn_ff && cur_state != player_pkg::st_paused) begin
        new_state = player_pkg::st_fast;
    end
endfunction

// position step at one beat pulse
function automatic player_pkg::beat_t position_on_beat(
    input player_pkg::player_state_t  cur_state,
    input player_pkg::beat_t          cur_pos
);
    case (cur_state)
        player_pkg::st_play:   return cur_pos + 8'd1;
        player_pkg::st_fast:   return cur_pos + 8'd2;
        // rewind sticks at song start
        player_pkg::st_rewind: return (cur_pos == 8'd0) ? 8'd0 : cur_pos - 8'd1;
        default:               return cur_pos;
    endcase
endfunction

`endif

// ==== verif/music_control_tb.sv ====
`timescale 1ns/1ps

module music_control_tb;

    localparam int debounce_width  = 3;
    localparam int beat_cycles     = 20;
    localparam int num_songs       = 4;
    localparam int debounce_len    = (1 << debounce_width) - 1;
    // cycles to wait for a press that should change nothing
    localparam int settle_bound    = debounce_len + 20;
    localparam int num_presses     = 24;
    localparam int max_beats       = 40;
    localparam int watchdog_cycles = num_presses * (debounce_len + 40)
                                     + max_beats * beat_cycles + 200;

    logic                      clk;
    logic                      rst_n;
    logic [3:0]                btn;
    logic [1:0]                sw;
    player_pkg::player_state_t state;
    player_pkg::song_t         song;
    player_pkg::beat_t         position;
    logic                      beat;

    // expected outputs, advanced by the model
    player_pkg::player_state_t exp_state;
    player_pkg::song_t         exp_song;
    player_pkg::beat_t         exp_pos;
    player_pkg::beat_t         p_ref;
    int                        beat_seen;
    int                        beats_before;
    int                        k;
    bit                        failed;

    `include "player_model.svh"

    music_control_top #(
        .DEBOUNCE_WIDTH (debounce_width),
        .BEAT_COUNT     (beat_cycles),
        .NUM_SONGS      (num_songs)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .btn      (btn),
        .sw       (sw),
        .state    (state),
        .song     (song),
        .position (position),
        .beat     (beat)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("run timed out after %0d cycles", watchdog_cycles);
        $display("Finished with errors");
        $fatal(1);
    end

    // ==============================
    // helpers
    // ==============================

    task automatic abort_run(input string msg);
        failed = 1'b1;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            failed = 1'b1;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // one cycle, sample and drive point 2 ns after the edge
    task automatic step();
        @(posedge clk);
        #2;
        if (beat === 1'b1) begin
            if (exp_state == player_pkg::st_paused) abort_run("beat pulse while paused");
            exp_pos   = position_on_beat(exp_state, exp_pos);
            beat_seen = beat_seen + 1;
        end
    endtask

    task automatic compare_outputs();
        check_value("state", 32'(state), 32'(exp_state));
        check_value("song", 32'(song), 32'(exp_song));
        check_value("position", 32'(position), 32'(exp_pos));
    endtask

    // any difference here is the effect of the press
    function automatic bit outputs_moved();
        return (state !== exp_state) || (song !== exp_song) || (position !== exp_pos);
    endfunction

    task automatic press_pins(input logic [3:0] pins, input int lb, input int hold);
        bit seen;
        int waited;
        seen   = 1'b0;
        waited = 0;
        btn    = pins;
        while (waited < hold + settle_bound && !seen) begin
            step();
            waited = waited + 1;
            if (waited == hold) btn = 4'b0000;
            if (outputs_moved()) seen = 1'b1;
        end
        predict_press(lb, num_songs, exp_state, exp_song, exp_pos,
                      exp_state, exp_song, exp_pos);
        // finish the hold so the next press starts from a release
        while (waited < hold + 3) begin
            step();
            waited = waited + 1;
            if (waited == hold) btn = 4'b0000;
        end
        compare_outputs();
    endtask

    function automatic int random_hold();
        return debounce_len + 5 + int'($urandom % 8);
    endfunction

    task automatic press_button(input int lb);
        logic [3:0] pins;
        case (lb)
            player_pkg::btn_stop: pins = 4'b1000;
            player_pkg::btn_play: pins = 4'b0100;
            player_pkg::btn_ff:   pins = 4'b0001;
            // next or rewind by panel mode
            default:              pins = 4'b0010;
        endcase
        press_pins(pins, lb, random_hold());
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            step();
            compare_outputs();
        end
    endtask

    task automatic wait_beats(input int n);
        int start;
        int waited;
        start  = beat_seen;
        waited = 0;
        while (beat_seen - start < n) begin
            if (waited >= n * (beat_cycles + 2)) abort_run("expected beat pulse did not arrive");
            step();
            waited = waited + 1;
            compare_outputs();
        end
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial begin
        void'($urandom(32'h5e29b316));
        clk       = 1'b0;
        rst_n     = 1'b0;
        btn       = 4'b0000;
        sw        = 2'b00;
        failed    = 1'b0;
        beat_seen = 0;
        exp_state = player_pkg::st_paused;
        exp_song  = 4'd0;
        exp_pos   = 8'd0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // reset values
        step();
        compare_outputs();
        check_value("beat", 32'(beat), 32'd0);
        idle(4);

        // basic panel, play toggle and song wrap
        press_button(player_pkg::btn_play);
        press_button(player_pkg::btn_play);
        repeat (4) press_button(player_pkg::btn_next);

        // transport panel, seek ignored while paused
        sw = ($urandom % 2 == 0) ? 2'b01 : 2'b11;
        idle(4);
        press_button(player_pkg::btn_rew);
        press_button(player_pkg::btn_ff);
        press_button(player_pkg::btn_play);
        press_button(player_pkg::btn_rew);
        press_button(player_pkg::btn_ff);
        press_button(player_pkg::btn_play);

        // beat advance per mode
        p_ref = exp_pos;
        wait_beats(3);
        check_value("position", 32'(position), 32'(p_ref) + 32'd3);
        press_button(player_pkg::btn_ff);
        p_ref = exp_pos;
        wait_beats(3);
        check_value("position", 32'(position), 32'(p_ref) + 32'd6);
        press_button(player_pkg::btn_rew);
        wait_beats(int'(exp_pos) + 3);
        check_value("position", 32'(position), 32'd0);
        press_button(player_pkg::btn_stop);
        press_button(player_pkg::btn_play);
        wait_beats(2);
        press_button(player_pkg::btn_play);
        // paused, position must hold
        p_ref        = exp_pos;
        beats_before = beat_seen;
        idle(3 * beat_cycles);
        check_value("beat count", 32'(beat_seen), 32'(beats_before));
        check_value("position", 32'(position), 32'(p_ref));
        press_button(player_pkg::btn_stop);
        check_value("position", 32'(position), 32'd0);

        // debounce, short glitch then one long hold
        sw = 2'b00;
        idle(4);
        btn = 4'b0010;
        repeat (1 + int'($urandom % 2)) step();
        btn = 4'b0000;
        idle(settle_bound);
        press_pins(4'b0010, player_pkg::btn_next, 60);

        // locked panel, nothing moves
        sw = 2'b10;
        idle(4);
        for (k = 0; k < 4; k++) begin
            press_pins(4'b0001 << k, -1, random_hold());
        end

        if (!failed) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
